// File: logic/sb_macros.svh
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

// instruction window
`define SB_WIN_DEPTH 16
`define SB_IDX_W 4

// architectural register file
`define SB_NREG 32
`define SB_REG_W 5

// datapath width
`define SB_DATA_W 32

// occupancy at which the front end is held off
// a few slots stay free to cover the registered stall
`define SB_STALL_LVL 12

// number of ALU stations
`define SB_NFU 2

`endif

// File: logic/sb_pkg.sv
`include "sb_macros.svh"

package sb_pkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLT,
        SLTU,
        SLL,
        SRL,
        LUI
    } alu_op_t;

    // instruction as delivered by the front end
    typedef struct packed {
        logic [31:0]           pc;
        logic                  fu;
        alu_op_t               op;
        logic [`SB_REG_W-1:0]  rd;
        logic [`SB_REG_W-1:0]  rs;
        logic                  rs_valid;
        logic [`SB_REG_W-1:0]  rt;
        logic                  rt_valid;
        logic [15:0]           imm;
        logic                  use_imm;
    } sb_inst_t;

    typedef struct packed {
        logic                  valid;
        logic [`SB_IDX_W-1:0]  idx;
        sb_inst_t              inst;
    } win_entry_t;

    typedef struct packed {
        logic                  valid;
        logic [`SB_IDX_W-1:0]  idx;
        alu_op_t               op;
        logic [15:0]           imm;
        logic                  use_imm;
    } alu_req_t;

    typedef struct packed {
        logic                  valid;
        logic [`SB_IDX_W-1:0]  idx;
        logic [`SB_DATA_W-1:0] data;
    } fu_result_t;

    typedef struct packed {
        logic                  valid;
        logic [`SB_IDX_W-1:0]  idx;
        logic [31:0]           pc;
        logic [`SB_REG_W-1:0]  rd;
        logic [`SB_DATA_W-1:0] data;
    } retire_t;

endpackage

// File: logic/regfile.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module regfile (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic [`SB_REG_W-1:0]  raddr [2*`SB_NFU],
    output logic [`SB_DATA_W-1:0] rdata [2*`SB_NFU],
    input  logic                  we,
    input  logic [`SB_REG_W-1:0]  waddr,
    input  logic [`SB_DATA_W-1:0] wdata
);

    logic [`SB_DATA_W-1:0] rf [`SB_NREG];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < `SB_NREG; i++) begin
                rf[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            rf[waddr] <= wdata;
        end
    end

    // write-first bypass, register 0 hardwired to zero
    always_comb begin
        for (int p = 0; p < 2*`SB_NFU; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else if (we && waddr == raddr[p]) begin
                rdata[p] = wdata;
            end else begin
                rdata[p] = rf[raddr[p]];
            end
        end
    end

endmodule

// File: logic/alu_unit.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module alu_unit (
    input  logic                  clk,
    input  logic                  resetn,
    input  sb_pkg::alu_req_t      req,
    input  logic [`SB_DATA_W-1:0] rdata1,
    input  logic [`SB_DATA_W-1:0] rdata2,
    output sb_pkg::fu_result_t    res
);
    import sb_pkg::*;

    logic                  v_q;
    logic [`SB_IDX_W-1:0]  idx_q;
    alu_op_t               op_q;
    logic [`SB_DATA_W-1:0] a_q;
    logic [`SB_DATA_W-1:0] b_q;
    logic [15:0]           imm_q;
    logic [`SB_DATA_W-1:0] result;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            v_q <= 1'b0;
        end else begin
            v_q <= req.valid;
        end
    end

    // operands captured on the issue edge
    always_ff @(posedge clk) begin
        if (req.valid) begin
            idx_q <= req.idx;
            op_q  <= req.op;
            imm_q <= req.imm;
            a_q   <= rdata1;
            b_q   <= req.use_imm ? {{(`SB_DATA_W-16){req.imm[15]}}, req.imm} : rdata2;
        end
    end

    always_comb begin
        case (op_q)
            ADD:     result = a_q + b_q;
            SUB:     result = a_q - b_q;
            AND:     result = a_q & b_q;
            OR:      result = a_q | b_q;
            XOR:     result = a_q ^ b_q;
            SLT:     result = {{(`SB_DATA_W-1){1'b0}}, $signed(a_q) < $signed(b_q)};
            SLTU:    result = {{(`SB_DATA_W-1){1'b0}}, a_q < b_q};
            SLL:     result = a_q << b_q[4:0];
            SRL:     result = a_q >> b_q[4:0];
            LUI:     result = {imm_q, 16'b0};
            default: result = '0;
        endcase
    end

    assign res.valid = v_q;
    assign res.idx   = idx_q;
    assign res.data  = result;

endmodule

// File: logic/inst_window.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module inst_window (
    input  logic               clk,
    input  logic               resetn,
    input  logic               inst_valid,
    input  sb_pkg::sb_inst_t   inst,
    output logic               stallreq,
    output sb_pkg::win_entry_t disp_entry,
    input  logic               disp_take,
    input  sb_pkg::fu_result_t fu_res [`SB_NFU],
    output sb_pkg::retire_t    retire
);
    import sb_pkg::*;

    sb_inst_t                 inst_mem [`SB_WIN_DEPTH];
    logic [`SB_DATA_W-1:0]    cb [`SB_WIN_DEPTH];
    logic [`SB_WIN_DEPTH-1:0] ent_valid;
    logic [`SB_WIN_DEPTH-1:0] ent_done;

    // pointers carry one wrap bit above the index
    logic [`SB_IDX_W:0]   wptr;
    logic [`SB_IDX_W:0]   dptr;
    logic [`SB_IDX_W:0]   rptr;
    logic [`SB_IDX_W:0]   wptr_nxt;
    logic [`SB_IDX_W:0]   rptr_nxt;
    logic [`SB_IDX_W:0]   occ_nxt;
    logic [`SB_IDX_W-1:0] waddr;
    logic [`SB_IDX_W-1:0] daddr;
    logic [`SB_IDX_W-1:0] raddr;
    logic                 accept;
    logic                 retire_en;
    logic                 stall_q;

    assign waddr = wptr[`SB_IDX_W-1:0];
    assign daddr = dptr[`SB_IDX_W-1:0];
    assign raddr = rptr[`SB_IDX_W-1:0];

    assign accept    = inst_valid & ~stall_q;
    assign retire_en = ent_valid[raddr] & ent_done[raddr];

    assign wptr_nxt = wptr + {{`SB_IDX_W{1'b0}}, accept};
    assign rptr_nxt = rptr + {{`SB_IDX_W{1'b0}}, retire_en};
    assign occ_nxt  = wptr_nxt - rptr_nxt;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wptr    <= '0;
            dptr    <= '0;
            rptr    <= '0;
            stall_q <= 1'b0;
        end else begin
            wptr    <= wptr_nxt;
            rptr    <= rptr_nxt;
            stall_q <= occ_nxt >= (`SB_IDX_W+1)'(`SB_STALL_LVL);
            if (disp_take) begin
                dptr <= dptr + 1'b1;
            end
        end
    end

    assign stallreq = stall_q;

    // entry status
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ent_valid <= '0;
            ent_done  <= '0;
        end else begin
            if (accept) begin
                ent_valid[waddr] <= 1'b1;
                ent_done[waddr]  <= 1'b0;
            end
            for (int k = 0; k < `SB_NFU; k++) begin
                if (fu_res[k].valid) begin
                    ent_done[fu_res[k].idx] <= 1'b1;
                end
            end
            // head leaves the window once its result is in
            if (retire_en) begin
                ent_valid[raddr] <= 1'b0;
            end
        end
    end

    // instruction store and commit buffer
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_mem[waddr] <= inst;
        end
        for (int k = 0; k < `SB_NFU; k++) begin
            if (fu_res[k].valid) begin
                cb[fu_res[k].idx] <= fu_res[k].data;
            end
        end
    end

    // dispatch pointer never passes the write pointer
    always_comb begin
        disp_entry.valid = ent_valid[daddr] & (dptr != wptr);
        disp_entry.idx   = daddr;
        disp_entry.inst  = inst_mem[daddr];
    end

    always_comb begin
        retire.valid = retire_en;
        retire.idx   = raddr;
        retire.pc    = inst_mem[raddr].pc;
        retire.rd    = inst_mem[raddr].rd;
        retire.data  = cb[raddr];
    end

endmodule

// File: logic/dispatch_ctrl.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module dispatch_ctrl (
    input  logic                 clk,
    input  logic                 resetn,
    input  sb_pkg::win_entry_t   disp_entry,
    output logic                 disp_take,
    input  sb_pkg::retire_t      retire,
    input  sb_pkg::fu_result_t   fu_res [`SB_NFU],
    output sb_pkg::alu_req_t     alu_req [`SB_NFU],
    output logic [`SB_REG_W-1:0] raddr [2*`SB_NFU]
);
    import sb_pkg::*;

    // register status: pending bit and producer window index
    logic [`SB_NREG-1:0]  pending;
    logic [`SB_IDX_W-1:0] tag [`SB_NREG];

    // station control
    logic [`SB_NFU-1:0] busy;
    logic [`SB_NFU-1:0] issued;
    logic [`SB_NFU-1:0] wait1;
    logic [`SB_NFU-1:0] wait2;
    logic [`SB_NFU-1:0] ready;

    // station payload
    logic [`SB_IDX_W-1:0] st_idx [`SB_NFU];
    alu_op_t              st_op [`SB_NFU];
    logic [15:0]          st_imm [`SB_NFU];
    logic [`SB_NFU-1:0]   st_use_imm;
    logic [`SB_REG_W-1:0] st_rs [`SB_NFU];
    logic [`SB_REG_W-1:0] st_rt [`SB_NFU];
    logic [`SB_IDX_W-1:0] st_t1 [`SB_NFU];
    logic [`SB_IDX_W-1:0] st_t2 [`SB_NFU];

    sb_inst_t din;
    logic     sel;
    logic     rd_busy;
    logic     rs_wait;
    logic     rt_wait;

    assign din = disp_entry.inst;
    assign sel = din.fu;

    // rd 0 is never tracked since pending[0] stays clear
    assign rd_busy   = pending[din.rd];
    assign disp_take = disp_entry.valid & ~busy[sel] & ~rd_busy;

    // a producer retiring right now no longer needs to be awaited
    assign rs_wait = din.rs_valid & pending[din.rs]
                   & ~(retire.valid & (retire.idx == tag[din.rs]));
    assign rt_wait = din.rt_valid & pending[din.rt]
                   & ~(retire.valid & (retire.idx == tag[din.rt]));

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pending <= '0;
        end else begin
            if (retire.valid && pending[retire.rd] && tag[retire.rd] == retire.idx) begin
                pending[retire.rd] <= 1'b0;
            end
            if (disp_take && din.rd != '0) begin
                pending[din.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_take) begin
            tag[din.rd] <= disp_entry.idx;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy   <= '0;
            issued <= '0;
            wait1  <= '0;
            wait2  <= '0;
        end else begin
            for (int s = 0; s < `SB_NFU; s++) begin
                if (ready[s]) begin
                    issued[s] <= 1'b1;
                end
                // result frees the station
                if (fu_res[s].valid) begin
                    busy[s] <= 1'b0;
                end
                if (retire.valid && wait1[s] && st_t1[s] == retire.idx) begin
                    wait1[s] <= 1'b0;
                end
                if (retire.valid && wait2[s] && st_t2[s] == retire.idx) begin
                    wait2[s] <= 1'b0;
                end
            end
            if (disp_take) begin
                busy[sel]   <= 1'b1;
                issued[sel] <= 1'b0;
                wait1[sel]  <= rs_wait;
                wait2[sel]  <= rt_wait;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (disp_take) begin
            st_idx[sel]     <= disp_entry.idx;
            st_op[sel]      <= din.op;
            st_imm[sel]     <= din.imm;
            st_use_imm[sel] <= din.use_imm;
            // unused sources read register 0
            st_rs[sel]      <= din.rs_valid ? din.rs : '0;
            st_rt[sel]      <= din.rt_valid ? din.rt : '0;
            st_t1[sel]      <= tag[din.rs];
            st_t2[sel]      <= tag[din.rt];
        end
    end

    assign ready = busy & ~issued & ~wait1 & ~wait2;

    always_comb begin
        for (int s = 0; s < `SB_NFU; s++) begin
            alu_req[s].valid   = ready[s];
            alu_req[s].idx     = st_idx[s];
            alu_req[s].op      = st_op[s];
            alu_req[s].imm     = st_imm[s];
            alu_req[s].use_imm = st_use_imm[s];
            raddr[2*s]         = st_rs[s];
            raddr[2*s+1]       = st_rt[s];
        end
    end

endmodule

// File: logic/sb_core.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_core (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  inst_valid,
    input  sb_pkg::sb_inst_t      inst,
    output logic                  stallreq,
    output logic [31:0]           debug_wb_pc,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [`SB_REG_W-1:0]  debug_wb_rf_wnum,
    output logic [`SB_DATA_W-1:0] debug_wb_rf_wdata
);
    import sb_pkg::*;

    win_entry_t            disp_entry;
    logic                  disp_take;
    fu_result_t            fu_res [`SB_NFU];
    alu_req_t              alu_req [`SB_NFU];
    retire_t               retire;
    logic [`SB_REG_W-1:0]  rf_raddr [2*`SB_NFU];
    logic [`SB_DATA_W-1:0] rf_rdata [2*`SB_NFU];

    inst_window i_inst_window (
        .clk        (clk),
        .resetn     (resetn),
        .inst_valid (inst_valid),
        .inst       (inst),
        .stallreq   (stallreq),
        .disp_entry (disp_entry),
        .disp_take  (disp_take),
        .fu_res     (fu_res),
        .retire     (retire)
    );

    dispatch_ctrl i_dispatch_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .disp_entry (disp_entry),
        .disp_take  (disp_take),
        .retire     (retire),
        .fu_res     (fu_res),
        .alu_req    (alu_req),
        .raddr      (rf_raddr)
    );

    // ALU1 reads ports 0 and 1, ALU2 reads ports 2 and 3
    alu_unit i_alu1 (
        .clk    (clk),
        .resetn (resetn),
        .req    (alu_req[0]),
        .rdata1 (rf_rdata[0]),
        .rdata2 (rf_rdata[1]),
        .res    (fu_res[0])
    );

    alu_unit i_alu2 (
        .clk    (clk),
        .resetn (resetn),
        .req    (alu_req[1]),
        .rdata1 (rf_rdata[2]),
        .rdata2 (rf_rdata[3]),
        .res    (fu_res[1])
    );

    regfile i_regfile (
        .clk    (clk),
        .resetn (resetn),
        .raddr  (rf_raddr),
        .rdata  (rf_rdata),
        .we     (retire.valid),
        .waddr  (retire.rd),
        .wdata  (retire.data)
    );

    // every retirement shows up, rd 0 included
    assign debug_wb_rf_wen   = {4{retire.valid}};
    assign debug_wb_pc       = retire.valid ? retire.pc : '0;
    assign debug_wb_rf_wnum  = retire.valid ? retire.rd : '0;
    assign debug_wb_rf_wdata = retire.valid ? retire.data : '0;

endmodule

// File: tb/sb_core_chk.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_core_chk (
    input  logic        clk,
    input  logic        resetn,
    input  logic        stallreq,
    input  logic [31:0] debug_wb_pc,
    input  logic [3:0]  debug_wb_rf_wen
);
    import sb_pkg::*;

    int          fail_cnt = 0;
    logic [31:0] last_pc;
    logic        have_pc;

    // pc of the most recent retirement
    always_ff @(posedge clk) begin
        if (!resetn) begin
            have_pc <= 1'b0;
        end else if (debug_wb_rf_wen[0]) begin
            last_pc <= debug_wb_pc;
            have_pc <= 1'b1;
        end
    end

    wen_same: assert property (@(posedge clk) disable iff (!resetn)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else begin
            fail_cnt++;
            $error("write enable bits differ");
        end

    wen_in_reset: assert property (@(posedge clk) !resetn |=> debug_wb_rf_wen == 4'h0)
        else begin
            fail_cnt++;
            $error("write enable seen during reset");
        end

    stall_known: assert property (@(posedge clk) disable iff (!resetn) !$isunknown(stallreq))
        else begin
            fail_cnt++;
            $error("stallreq is unknown");
        end

    // tests number their pcs in steps of 4
    pc_step: assert property (@(posedge clk) disable iff (!resetn)
        (debug_wb_rf_wen[0] && have_pc) |-> debug_wb_pc == last_pc + 32'd4)
        else begin
            fail_cnt++;
            $error("retired pc does not follow the previous one");
        end

endmodule

bind sb_core sb_core_chk i_sb_core_chk (
    .clk             (clk),
    .resetn          (resetn),
    .stallreq        (stallreq),
    .debug_wb_pc     (debug_wb_pc),
    .debug_wb_rf_wen (debug_wb_rf_wen)
);

// File: tb/sb_core_tb.sv
`timescale 1ns/1ps
`include "sb_macros.svh"

module sb_core_tb;
    import sb_pkg::*;

    logic                  clk;
    logic                  resetn;
    logic                  inst_valid;
    sb_inst_t              inst;
    logic                  stallreq;
    logic [31:0]           debug_wb_pc;
    logic [3:0]            debug_wb_rf_wen;
    logic [`SB_REG_W-1:0]  debug_wb_rf_wnum;
    logic [`SB_DATA_W-1:0] debug_wb_rf_wdata;

    // architectural state of the reference model
    logic [31:0] regs [`SB_NREG];
    logic [31:0] exp_pc [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    logic [31:0] next_pc;
    int          seed;
    int          sent_cnt;
    int          cycle_cnt;
    logic        stall_seen;

    sb_core i_sb_core (
        .clk               (clk),
        .resetn            (resetn),
        .inst_valid        (inst_valid),
        .inst              (inst),
        .stallreq          (stallreq),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("TEST FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] alu_model(input alu_op_t op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [15:0] imm);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            LUI:     return {imm, 16'h0000};
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic [15:0] rand_imm();
        logic [31:0] v;
        v = $random(seed);
        return v[15:0];
    endfunction

    function automatic alu_op_t rand_op();
        int unsigned v;
        v = $random(seed);
        return alu_op_t'(v % 10);
    endfunction

    // source register is always read, rt only when no immediate is used
    task automatic send_inst(input logic fu, input alu_op_t op, input logic [4:0] rd,
                             input logic [4:0] rs, input logic [4:0] rt,
                             input logic [15:0] imm, input logic use_imm);
        logic [31:0] b;
        logic [31:0] res;
        logic        taken;
        b = use_imm ? {{16{imm[15]}}, imm} : regs[rt];
        res = alu_model(op, regs[rs], b, imm);
        inst.pc       = next_pc;
        inst.fu       = fu;
        inst.op       = op;
        inst.rd       = rd;
        inst.rs       = rs;
        inst.rs_valid = 1'b1;
        inst.rt       = rt;
        inst.rt_valid = ~use_imm;
        inst.imm      = imm;
        inst.use_imm  = use_imm;
        inst_valid    = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !stallreq;
            @(posedge clk);
            #2;
        end
        inst_valid = 1'b0;
        exp_pc.push_back(next_pc);
        exp_rd.push_back(rd);
        exp_data.push_back(res);
        if (rd != 5'd0) begin
            regs[rd] = res;
        end
        next_pc = next_pc + 32'd4;
        sent_cnt++;
    endtask

    task automatic wait_drain();
        while (exp_pc.size() != 0) @(posedge clk);
        repeat (3) @(posedge clk);
        #2;
    endtask

    task automatic reset_idle();
        @(negedge clk);
        check_eq("stallreq", stallreq, 32'd0);
        check_eq("debug_wb_rf_wen", debug_wb_rf_wen, 32'd0);
        repeat (10) @(posedge clk);
        #2;
    endtask

    task automatic imm_ops();
        for (int r = 20; r < 24; r++) begin
            send_inst(r[0], LUI, 5'(r), 5'd0, 5'd0, rand_imm(), 1'b1);
            send_inst(r[1], OR, 5'(r), 5'(r), 5'd0, rand_imm(), 1'b1);
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int k = 0; k < 10; k++) begin
                send_inst(k[0] ^ pass[0], alu_op_t'(k), 5'(1 + k), 5'(20 + k % 4), 5'd0,
                          rand_imm(), 1'b1);
            end
        end
        wait_drain();
    endtask

    // each instruction reads the rd of the one before it
    task automatic raw_chain();
        logic [4:0] prev;
        logic [4:0] rd;
        prev = 5'd20;
        for (int i = 0; i < 16; i++) begin
            rd = 5'(1 + i % 8);
            send_inst(i[0], rand_op(), rd, prev, 5'(20 + i % 4), rand_imm(), i[1]);
            prev = rd;
        end
        wait_drain();
    endtask

    task automatic reg_reuse();
        send_inst(1'b0, ADD, 5'd5, 5'd0, 5'd0, 16'h1234, 1'b1);
        send_inst(1'b1, ADD, 5'd5, 5'd5, 5'd0, 16'h0101, 1'b1);
        send_inst(1'b0, XOR, 5'd5, 5'd0, 5'd0, 16'h8000, 1'b1);
        send_inst(1'b1, SUB, 5'd6, 5'd5, 5'd20, 16'h0000, 1'b0);
        // result goes nowhere, r0 stays zero
        send_inst(1'b0, ADD, 5'd0, 5'd21, 5'd0, 16'h7777, 1'b1);
        send_inst(1'b1, OR, 5'd7, 5'd0, 5'd0, 16'h0000, 1'b0);
        send_inst(1'b0, ADD, 5'd8, 5'd0, 5'd5, 16'h0000, 1'b0);
        send_inst(1'b1, ADD, 5'd9, 5'd6, 5'd5, 16'h0000, 1'b0);
        wait_drain();
    endtask

    task automatic stall_burst();
        logic [4:0] prev;
        logic [4:0] rd;
        stall_seen = 1'b0;
        prev = 5'd7;
        for (int i = 0; i < 20; i++) begin
            rd = 5'(9 + i % 12);
            send_inst(i[0], rand_op(), rd, prev, 5'd0, rand_imm(), 1'b1);
            prev = rd;
        end
        wait_drain();
        check_eq("stall_seen", stall_seen, 32'd1);
    endtask

    // retirements are compared in the middle of the cycle
    always @(negedge clk) begin
        if (resetn === 1'b1 && stallreq === 1'b1) begin
            stall_seen = 1'b1;
        end
        if (i_sb_core.i_sb_core_chk.fail_cnt != 0) begin
            $display("an assertion on the DUT ports failed at %0t ns", $time);
            $display("TEST FAILED");
            $fatal(1, "assertion failure");
        end else if (resetn === 1'b1 && debug_wb_rf_wen !== 4'h0) begin
            if (exp_pc.size() == 0) begin
                $display("retirement of pc %h at %0t ns with nothing outstanding",
                         debug_wb_pc, $time);
                $display("TEST FAILED");
                $fatal(1, "unexpected retirement");
            end else begin
                check_eq("debug_wb_rf_wen", debug_wb_rf_wen, 32'hf);
                check_eq("debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                check_eq("debug_wb_rf_wnum", debug_wb_rf_wnum, exp_rd.pop_front());
                check_eq("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data.pop_front());
            end
        end
    end

    initial begin
        cycle_cnt = 0;
        forever begin
            @(posedge clk);
            cycle_cnt++;
            if (cycle_cnt > 60 * (sent_cnt + 1) + 20) begin
                $display("watchdog expired after %0d cycles, %0d retirements outstanding",
                         cycle_cnt, exp_pc.size());
                $display("TEST FAILED");
                $fatal(1, "hang");
            end
        end
    end

    initial begin
        seed       = 27;
        resetn     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        next_pc    = 32'h0000_1000;
        sent_cnt   = 0;
        stall_seen = 1'b0;
        for (int r = 0; r < `SB_NREG; r++) begin
            regs[r] = 32'h0;
        end
        repeat (4) @(posedge clk);
        #2;
        resetn = 1'b1;
        reset_idle();
        imm_ops();
        raw_chain();
        reg_reuse();
        stall_burst();
        if (i_sb_core.i_sb_core_chk.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: sb_core.f
+incdir+logic
logic/sb_pkg.sv
logic/regfile.sv
logic/alu_unit.sv
logic/inst_window.sv
logic/dispatch_ctrl.sv
logic/sb_core.sv
tb/sb_core_chk.sv
tb/sb_core_tb.sv
